// File: src/spi_pkg.sv
/*
 * Shared definitions for the SPI master subsystem
 *   - byte width and default sck divider exponent
 *   - state encodings of the shift engine and the frame controller
 */

`default_nettype none

package spi_pkg;

  // Byte width on the SPI wire and on the host side
  localparam int DATA_W = 8;

  // Default divider exponent, sck period is 2**CLK_DIV clocks
  localparam int CLK_DIV_DEF = 3;

  // Shift engine states
  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    TRANSFER  = 2'd1,
    WAIT_HALF = 2'd2
  } master_state_e;

  // Frame controller states
  typedef enum logic [2:0] {
    F_IDLE  = 3'd0,
    F_SETUP = 3'd1,
    F_XFER  = 3'd2,
    F_WAIT  = 3'd3,
    F_HOLD  = 3'd4
  } frame_state_e;

endpackage

`default_nettype wire

// File: src/spi_byte_if.sv
/*
 * Byte-level link between the frame controller and the shift engine
 *   - start pulse and transmit byte from the controller
 *   - busy level, done pulse and received byte from the engine
 */

`timescale 1ns/1ps
`default_nettype none

interface spi_byte_if;

  logic                       start;
  logic [spi_pkg::DATA_W-1:0] tx_byte;
  logic                       busy;
  // One-cycle pulse, rx_byte valid alongside it
  logic                       done;
  logic [spi_pkg::DATA_W-1:0] rx_byte;

  modport ctrl (output start, output tx_byte, input busy, input done, input rx_byte);

  modport master (input start, input tx_byte, output busy, output done, output rx_byte);

endinterface

`default_nettype wire

// File: src/spi_master.sv
/*
 * Byte-wide SPI shift engine
 *   - sck idle high, period of 2**CLK_DIV clocks
 *   - mosi set up at the start of each sck period, MSB first
 *   - miso captured in the last cycle of the high half
 *   - half-period tail before done
 */

`timescale 1ns/1ps
`default_nettype none

module spi_master #(
  parameter int CLK_DIV = 3
) (
  input  logic       clk,
  input  logic       rst,
  spi_byte_if.master byte_bus,
  input  logic       miso,
  output logic       sck,
  output logic       mosi
);

  localparam int DATA_W = spi_pkg::DATA_W;
  localparam int CNT_W  = $clog2(DATA_W);

  // Phase points within one sck period
  localparam logic [CLK_DIV-1:0] PHASE_MID = {1'b0, {(CLK_DIV-1){1'b1}}};
  localparam logic [CLK_DIV-1:0] PHASE_END = {CLK_DIV{1'b1}};
  localparam logic [CNT_W-1:0]   LAST_BIT  = CNT_W'(DATA_W - 1);

  spi_pkg::master_state_e state_d, state_q;

  logic [CLK_DIV-1:0] phase_d, phase_q;
  logic [CNT_W-1:0]   bit_d, bit_q;
  logic               mosi_d, mosi_q;
  logic               done_d, done_q;
  logic [DATA_W-1:0]  shift_d, shift_q;
  logic [DATA_W-1:0]  rx_d, rx_q;

  // High half first, then low half, only while shifting
  assign sck  = ~(phase_q[CLK_DIV-1] & (state_q == spi_pkg::TRANSFER));
  assign mosi = mosi_q;

  assign byte_bus.busy    = (state_q != spi_pkg::IDLE);
  assign byte_bus.done    = done_q;
  assign byte_bus.rx_byte = rx_q;

  always_comb begin
    state_d = state_q;
    phase_d = phase_q;
    bit_d   = bit_q;
    mosi_d  = mosi_q;
    done_d  = 1'b0;
    shift_d = shift_q;
    rx_d    = rx_q;

    case (state_q)
      spi_pkg::IDLE: begin
        phase_d = '0;
        bit_d   = '0;
        mosi_d  = 1'b0;
        if (byte_bus.start) begin
          shift_d = byte_bus.tx_byte;
          state_d = spi_pkg::TRANSFER;
        end
      end

      spi_pkg::TRANSFER: begin
        phase_d = phase_q + 1'b1;
        if (phase_q == '0) begin
          // New period, present the next bit
          mosi_d = shift_q[DATA_W-1];
        end else if (phase_q == PHASE_MID) begin
          // Just before sck falls
          shift_d = {shift_q[DATA_W-2:0], miso};
        end else if (phase_q == PHASE_END) begin
          bit_d = bit_q + 1'b1;
          if (bit_q == LAST_BIT) begin
            rx_d    = shift_q;
            state_d = spi_pkg::WAIT_HALF;
          end
        end
      end

      spi_pkg::WAIT_HALF: begin
        // sck stays high for half a period before the byte is reported
        phase_d = phase_q + 1'b1;
        if (phase_q == PHASE_MID) begin
          phase_d = '0;
          done_d  = 1'b1;
          state_d = spi_pkg::IDLE;
        end
      end

      default: begin
        state_d = spi_pkg::IDLE;
      end
    endcase
  end

  // Control state
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= spi_pkg::IDLE;
      phase_q <= '0;
      bit_q   <= '0;
      mosi_q  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      phase_q <= phase_d;
      bit_q   <= bit_d;
      mosi_q  <= mosi_d;
      done_q  <= done_d;
    end
  end

  // Data path
  always_ff @(posedge clk) begin
    shift_q <= shift_d;
    rx_q    <= rx_d;
  end

endmodule

`default_nettype wire

// File: src/spi_frame_ctrl.sv
/*
 * SPI frame controller
 *   - groups host bytes into frames under one active-low chip select
 *   - half-period setup gap after cs_n falls, hold gap before it rises
 *   - returns each received byte with a one-cycle rx_valid strobe
 */

`timescale 1ns/1ps
`default_nettype none

module spi_frame_ctrl #(
  parameter int CLK_DIV = 3
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       byte_start,
  input  logic                       tx_last,
  input  logic [spi_pkg::DATA_W-1:0] tx_data,
  output logic                       busy,
  output logic                       rx_valid,
  output logic                       cs_n,
  output logic [spi_pkg::DATA_W-1:0] rx_data,
  spi_byte_if.ctrl                   byte_bus
);

  // Gap counter covers half an sck period
  localparam int GAP_W = CLK_DIV - 1;

  spi_pkg::frame_state_e state_q;

  logic [GAP_W-1:0]           gap_q;
  logic                       gap_end;
  logic                       accept;
  logic                       cs_n_q;
  logic                       start_q;
  logic                       rx_valid_q;
  logic                       last_q;
  logic [spi_pkg::DATA_W-1:0] tx_q;
  logic [spi_pkg::DATA_W-1:0] rx_q;

  // Ready for a byte when idle or parked mid-frame
  assign busy    = !(state_q == spi_pkg::F_IDLE || state_q == spi_pkg::F_WAIT);
  assign accept  = byte_start & ~busy;
  assign gap_end = (gap_q == {GAP_W{1'b1}});

  assign cs_n     = cs_n_q;
  assign rx_valid = rx_valid_q;
  assign rx_data  = rx_q;

  assign byte_bus.start   = start_q;
  assign byte_bus.tx_byte = tx_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= spi_pkg::F_IDLE;
      gap_q      <= '0;
      cs_n_q     <= 1'b1;
      start_q    <= 1'b0;
      rx_valid_q <= 1'b0;
      last_q     <= 1'b0;
    end else begin
      start_q    <= 1'b0;
      rx_valid_q <= 1'b0;

      case (state_q)
        spi_pkg::F_IDLE: begin
          if (accept) begin
            cs_n_q  <= 1'b0;
            gap_q   <= '0;
            last_q  <= tx_last;
            state_q <= spi_pkg::F_SETUP;
          end
        end

        spi_pkg::F_SETUP: begin
          if (!gap_end) begin
            gap_q <= gap_q + 1'b1;
          end else if (!byte_bus.busy) begin
            start_q <= 1'b1;
            state_q <= spi_pkg::F_XFER;
          end
        end

        spi_pkg::F_XFER: begin
          if (byte_bus.done) begin
            rx_valid_q <= 1'b1;
            if (last_q) begin
              gap_q   <= '0;
              state_q <= spi_pkg::F_HOLD;
            end else begin
              state_q <= spi_pkg::F_WAIT;
            end
          end
        end

        spi_pkg::F_WAIT: begin
          // cs_n already low, no setup gap between bytes
          if (accept) begin
            last_q  <= tx_last;
            start_q <= 1'b1;
            state_q <= spi_pkg::F_XFER;
          end
        end

        spi_pkg::F_HOLD: begin
          if (!gap_end) begin
            gap_q <= gap_q + 1'b1;
          end else begin
            cs_n_q  <= 1'b1;
            state_q <= spi_pkg::F_IDLE;
          end
        end

        default: begin
          state_q <= spi_pkg::F_IDLE;
        end
      endcase
    end
  end

  // Byte holding registers
  always_ff @(posedge clk) begin
    if (accept) begin
      tx_q <= tx_data;
    end
    if (state_q == spi_pkg::F_XFER && byte_bus.done) begin
      rx_q <= byte_bus.rx_byte;
    end
  end

endmodule

`default_nettype wire

// File: src/spi_top.sv
/*
 * SPI master subsystem top level
 *   - frame controller on the host side
 *   - shift engine on the SPI side
 *   - byte link between them
 */

`timescale 1ns/1ps
`default_nettype none

module spi_top #(
  parameter int CLK_DIV = spi_pkg::CLK_DIV_DEF
) (
  input  logic                       clk,
  input  logic                       rst,

  // Host side
  input  logic                       byte_start,
  input  logic [spi_pkg::DATA_W-1:0] tx_data,
  input  logic                       tx_last,
  output logic                       busy,
  output logic                       rx_valid,
  output logic [spi_pkg::DATA_W-1:0] rx_data,

  // SPI side
  output logic                       cs_n,
  output logic                       sck,
  output logic                       mosi,
  input  logic                       miso
);

  spi_byte_if byte_bus ();

  spi_frame_ctrl #(
    .CLK_DIV (CLK_DIV)
  ) u_frame_ctrl (
    .clk        (clk),
    .rst        (rst),
    .byte_start (byte_start),
    .tx_last    (tx_last),
    .tx_data    (tx_data),
    .busy       (busy),
    .rx_valid   (rx_valid),
    .cs_n       (cs_n),
    .rx_data    (rx_data),
    .byte_bus   (byte_bus.ctrl)
  );

  spi_master #(
    .CLK_DIV (CLK_DIV)
  ) u_master (
    .clk      (clk),
    .rst      (rst),
    .byte_bus (byte_bus.master),
    .miso     (miso),
    .sck      (sck),
    .mosi     (mosi)
  );

endmodule

`default_nettype wire

// File: verif/spi_props.sv
/*
 * Protocol assertions for the SPI master subsystem, bound to spi_top
 *   - reset values, sck idle while deselected
 *   - cs_n rises only after the host byte marked last has come back
 *   - rx_valid width and engine start condition
 */

`timescale 1ns/1ps
`default_nettype none

module spi_props (
  input logic                   clk,
  input logic                   rst,
  input logic                   cs_n,
  input logic                   sck,
  input logic                   busy,
  input logic                   rx_valid,
  input logic                   byte_start,
  input logic                   tx_last,
  input logic                   start,
  input spi_pkg::master_state_e m_state,
  input spi_pkg::frame_state_e  f_state
);

  int fail_count = 0;

  // Host byte marked last and whether its response has returned
  logic last_pending;
  logic last_returned;

  always @(posedge clk) begin
    if (rst) begin
      last_pending  <= 1'b0;
      last_returned <= 1'b0;
    end else begin
      if (byte_start && !busy) begin
        last_pending <= tx_last;
      end
      if (cs_n) begin
        last_returned <= 1'b0;
      end else if (rx_valid && last_pending) begin
        last_returned <= 1'b1;
      end
    end
  end

  reset_values: assert property (@(posedge clk) $fell(rst) |-> cs_n && sck && !busy && !rx_valid)
    else begin
      fail_count = fail_count + 1;
      $error("outputs not at their reset values when reset ends");
    end

  sck_idle_deselected: assert property (@(posedge clk) disable iff (rst) cs_n |-> sck)
    else begin
      fail_count = fail_count + 1;
      $error("sck low while cs_n is high");
    end

  // Frame closes from the hold gap once the byte marked last is back
  cs_close: assert property (@(posedge clk) disable iff (rst)
    $rose(cs_n) |-> ($past(f_state) == spi_pkg::F_HOLD) && last_returned)
    else begin
      fail_count = fail_count + 1;
      $error("cs_n rose without a completed last byte");
    end

  rx_pulse: assert property (@(posedge clk) disable iff (rst) rx_valid |=> !rx_valid)
    else begin
      fail_count = fail_count + 1;
      $error("rx_valid high for more than one cycle");
    end

  start_idle: assert property (@(posedge clk) disable iff (rst)
    start |-> (m_state == spi_pkg::IDLE))
    else begin
      fail_count = fail_count + 1;
      $error("engine started while not idle");
    end

endmodule

`default_nettype wire

// File: verif/spi_checker.sv
/*
 * Scoreboard for the SPI master subsystem
 *   - reset values on the host and SPI ports
 *   - rx_data against queued expected bytes on each rx_valid
 *   - bytes captured by the slave model against the bytes sent
 */

`timescale 1ns/1ps
`default_nettype none

module spi_checker (
  input  logic       clk,
  input  logic       rst,
  input  logic       busy,
  input  logic       rx_valid,
  input  logic [7:0] rx_data,
  input  logic       cs_n,
  input  logic       sck,
  input  logic       exp_push,
  input  logic [7:0] exp_rx,
  input  logic [7:0] exp_tx,
  input  int         slave_count,
  input  logic [7:0] slave_byte,
  input  logic       end_check,
  output int         host_errors,
  output int         wire_errors
);

  logic [7:0] rx_exp_q[$];
  logic [7:0] tx_sent_q[$];
  int         seen_count;
  logic       rst_prev;

  initial begin
    host_errors = 0;
    wire_errors = 0;
    seen_count  = 0;
    rst_prev    = 1'b0;
  end

  function automatic int mismatch(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("FAIL t=%0t %s expected=%h actual=%h", $time, name, exp, act);
      return 1;
    end
    return 0;
  endfunction

  always @(posedge clk) begin
    // First edge after reset ends
    if (rst_prev && !rst) begin
      host_errors += mismatch("cs_n", 8'h01, {7'd0, cs_n});
      host_errors += mismatch("sck", 8'h01, {7'd0, sck});
      host_errors += mismatch("busy", 8'h00, {7'd0, busy});
      host_errors += mismatch("rx_valid", 8'h00, {7'd0, rx_valid});
    end
    rst_prev = rst;

    if (exp_push) begin
      rx_exp_q.push_back(exp_rx);
      tx_sent_q.push_back(exp_tx);
    end

    if (rx_valid && !rst) begin
      if (rx_exp_q.size() == 0) begin
        $display("Error at %0t: rx_valid pulsed with no byte outstanding", $time);
        host_errors++;
      end else begin
        host_errors += mismatch("rx_data", rx_exp_q.pop_front(), rx_data);
      end
    end

    // Slave model finished another byte
    if (slave_count != seen_count) begin
      seen_count = slave_count;
      if (tx_sent_q.size() == 0) begin
        $display("Error at %0t: slave received a byte that was never sent", $time);
        wire_errors++;
      end else begin
        wire_errors += mismatch("mosi", tx_sent_q.pop_front(), slave_byte);
      end
    end

    if (end_check) begin
      if (rx_exp_q.size() != 0) begin
        $display("Error: %0d received bytes never came back", rx_exp_q.size());
        host_errors += rx_exp_q.size();
      end
      if (tx_sent_q.size() != 0) begin
        $display("Error: %0d sent bytes never reached the slave", tx_sent_q.size());
        wire_errors += tx_sent_q.size();
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_spi_top.sv
/*
 * Testbench for the SPI master subsystem
 *   - clock, reset and LFSR-driven frames of one to four bytes
 *   - SPI slave model, sck idle high, answers 5A then previous byte ^ 5A
 *   - reference function for received bytes, checker and assertions
 *   - closing summary
 */

`timescale 1ns/1ps
`default_nettype none

module tb_spi_top;

  localparam int          NUM_FRAMES  = 14;
  localparam int          TIMEOUT_CYC = 500;
  localparam logic [31:0] SEED        = 32'h65c5_9a91;

  logic       clk;
  logic       rst;
  logic       byte_start;
  logic       tx_last;
  logic [7:0] tx_data;
  logic       busy;
  logic       rx_valid;
  logic [7:0] rx_data;
  logic       cs_n;
  logic       sck;
  logic       mosi;
  logic       miso;

  // Expected bytes handed to the checker
  logic       exp_push;
  logic [7:0] exp_rx;
  logic [7:0] exp_tx;
  logic       end_check;
  int         host_errors;
  int         wire_errors;
  int         timeouts;

  logic [31:0] lfsr;
  logic [7:0]  data;
  logic [7:0]  prev;
  logic [7:0]  r;
  int          len;
  int          f;
  int          k;
  int          total;

  // Slave model state
  logic [7:0] slave_resp  = 8'h00;
  logic [7:0] slave_shift = 8'h00;
  logic [7:0] slave_byte  = 8'h00;
  int         slave_bits  = 0;
  int         slave_count = 0;

  spi_top #(
    .CLK_DIV (3)
  ) UUT (
    .clk        (clk),
    .rst        (rst),
    .byte_start (byte_start),
    .tx_data    (tx_data),
    .tx_last    (tx_last),
    .busy       (busy),
    .rx_valid   (rx_valid),
    .rx_data    (rx_data),
    .cs_n       (cs_n),
    .sck        (sck),
    .mosi       (mosi),
    .miso       (miso)
  );

  spi_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .busy        (busy),
    .rx_valid    (rx_valid),
    .rx_data     (rx_data),
    .cs_n        (cs_n),
    .sck         (sck),
    .exp_push    (exp_push),
    .exp_rx      (exp_rx),
    .exp_tx      (exp_tx),
    .slave_count (slave_count),
    .slave_byte  (slave_byte),
    .end_check   (end_check),
    .host_errors (host_errors),
    .wire_errors (wire_errors)
  );

  bind spi_top spi_props u_props (
    .clk        (clk),
    .rst        (rst),
    .cs_n       (cs_n),
    .sck        (sck),
    .busy       (busy),
    .rx_valid   (rx_valid),
    .byte_start (byte_start),
    .tx_last    (tx_last),
    .start      (byte_bus.start),
    .m_state    (u_master.state_q),
    .f_state    (u_frame_ctrl.state_q)
  );

  always #5 clk = ~clk;

  // Slave loads 5A on select and shifts after each sck fall
  always @(negedge cs_n or negedge sck) begin
    if (sck) begin
      slave_resp = 8'h5A;
      slave_bits = 0;
      miso = slave_resp[7];
    end else if (!cs_n) begin
      slave_shift = {slave_shift[6:0], mosi};
      slave_bits++;
      if (slave_bits == 8) begin
        slave_byte  = slave_shift;
        slave_count++;
        slave_bits  = 0;
        slave_resp  = slave_shift ^ 8'h5A;
      end else begin
        slave_resp = slave_resp << 1;
      end
      miso = slave_resp[7];
    end
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Expected response to byte k of a frame
  function automatic logic [7:0] expected_rx(input int idx, input logic [7:0] prev_tx);
    if (idx == 0) begin
      return 8'h5A;
    end
    return prev_tx ^ 8'h5A;
  endfunction

  task automatic take_bits(input int n, output logic [7:0] val);
    int i;
    val = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val = {val[6:0], lfsr[0]};
    end
  endtask

  task automatic send_byte(input logic [7:0] d, input logic last, input logic [7:0] exp);
    byte_start = 1'b1;
    tx_data    = d;
    tx_last    = last;
    exp_push   = 1'b1;
    exp_rx     = exp;
    exp_tx     = d;
    @(negedge clk);
    byte_start = 1'b0;
    tx_last    = 1'b0;
    exp_push   = 1'b0;
  endtask

  // Extra pulse while busy that the DUT must drop
  task automatic poke_while_busy(input logic [7:0] d);
    if (busy) begin
      byte_start = 1'b1;
      tx_data    = d;
      tx_last    = 1'b1;
      @(negedge clk);
      byte_start = 1'b0;
      tx_last    = 1'b0;
    end
  endtask

  task automatic wait_rx_valid();
    int n;
    n = 0;
    while (!rx_valid && n < TIMEOUT_CYC) begin
      @(negedge clk);
      n++;
    end
    if (!rx_valid) begin
      $display("Timeout at %0t: no rx_valid within %0d cycles", $time, TIMEOUT_CYC);
      timeouts++;
    end
  endtask

  task automatic wait_not_busy();
    int n;
    n = 0;
    while (busy && n < TIMEOUT_CYC) begin
      @(negedge clk);
      n++;
    end
    if (busy) begin
      $display("Timeout at %0t: busy stayed high for %0d cycles", $time, TIMEOUT_CYC);
      timeouts++;
    end
  endtask

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    byte_start = 1'b0;
    tx_last    = 1'b0;
    tx_data    = 8'h00;
    miso       = 1'b0;
    exp_push   = 1'b0;
    exp_rx     = 8'h00;
    exp_tx     = 8'h00;
    end_check  = 1'b0;
    timeouts   = 0;
    lfsr       = SEED;
    prev       = 8'h00;

    repeat (16) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    for (f = 0; f < NUM_FRAMES && timeouts == 0; f++) begin
      // First two frames carry one byte and later ones one to four
      take_bits(2, r);
      len = (f < 2) ? 1 : int'(r) + 1;
      for (k = 0; k < len && timeouts == 0; k++) begin
        take_bits(8, data);
        send_byte(data, k == len - 1, expected_rx(k, prev));
        prev = data;
        take_bits(1, r);
        if (r[0]) begin
          take_bits(8, r);
          poke_while_busy(r);
        end
        wait_rx_valid();
        if (timeouts == 0) begin
          wait_not_busy();
        end
      end
    end

    repeat (4) @(negedge clk);
    end_check = 1'b1;
    @(negedge clk);
    end_check = 1'b0;
    @(negedge clk);

    total = host_errors + wire_errors + UUT.u_props.fail_count + timeouts;
    $display("Summary: %0d host errors, %0d mosi errors, %0d assertion failures, %0d timeouts",
             host_errors, wire_errors, UUT.u_props.fail_count, timeouts);
    if (total == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
src/spi_pkg.sv
src/spi_byte_if.sv
src/spi_master.sv
src/spi_frame_ctrl.sv
src/spi_top.sv
verif/spi_props.sv
verif/spi_checker.sv
verif/tb_spi_top.sv

// File: Bender.yml
package:
  name: spi_master_subsystem

sources:
  # RTL in compile order
  - src/spi_pkg.sv
  - src/spi_byte_if.sv
  - src/spi_master.sv
  - src/spi_frame_ctrl.sv
  - src/spi_top.sv

  # Testbench
  - target: test
    files:
      - verif/spi_props.sv
      - verif/spi_checker.sv
      - verif/tb_spi_top.sv
